/* verilog/phold_pkg.sv */
package phold_pkg;

   localparam int MSG_WID = 32;
   localparam int TIME_WID = 16;
   localparam int HIST_WID = 32;
   localparam int RBK_OFFSET_WID = 8;
   localparam int TIME_RND_WID = 6;
   localparam int NB_RND = 24;
   // widest LP id the field functions carry
   localparam int LPID_MAX_WID = 8;

   localparam logic [RBK_OFFSET_WID-1:0] MIN_EVT_GAP = 8'd10;
   localparam logic EVT_REGULAR = 1'b0;
   localparam logic EVT_CANCEL = 1'b1;

   // history entry is {target, offset, type, time}
   localparam int HIST_TYPE_BIT = TIME_WID;
   localparam int HIST_OFF_LSB = TIME_WID + 1;
   localparam int HIST_TGT_LSB = HIST_OFF_LSB + RBK_OFFSET_WID;

   typedef logic [HIST_WID-1:0] hist_t;
   typedef logic [LPID_MAX_WID-1:0] lp_t;

   typedef enum logic [2:0] {
      IDLE,
      READ_HIST,
      GEN_EVT,
      WRITE_HIST,
      SEND_EVT,
      WAIT
   } core_state_t;

   typedef enum logic [1:0] {
      HIST_IDLE,
      HIST_REQ,
      HIST_WAIT
   } hist_state_t;

   function automatic lp_t lp_mask(int nb_lpid);
      return lp_t'((1 << nb_lpid) - 1);
   endfunction

   // message is {0.., type, lp, time}
   function automatic logic [MSG_WID-1:0] make_msg(logic typ, lp_t lp,
                                                   logic [TIME_WID-1:0] tm, int nb_lpid);
      logic [MSG_WID-1:0] m;
      m = {{(MSG_WID-TIME_WID){1'b0}}, tm};
      m = m | (MSG_WID'(lp & lp_mask(nb_lpid)) << TIME_WID);
      m[TIME_WID + nb_lpid] = typ;
      return m;
   endfunction

   function automatic logic [TIME_WID-1:0] msg_time(logic [MSG_WID-1:0] m);
      return m[TIME_WID-1:0];
   endfunction

   function automatic lp_t msg_lp(logic [MSG_WID-1:0] m, int nb_lpid);
      return lp_t'(m >> TIME_WID) & lp_mask(nb_lpid);
   endfunction

   function automatic logic msg_type(logic [MSG_WID-1:0] m, int nb_lpid);
      return m[TIME_WID + nb_lpid];
   endfunction

   function automatic logic [TIME_WID-1:0] hist_time(hist_t e);
      return e[TIME_WID-1:0];
   endfunction

   function automatic logic hist_type(hist_t e);
      return e[HIST_TYPE_BIT];
   endfunction

   function automatic logic [RBK_OFFSET_WID-1:0] hist_offset(hist_t e);
      return e[HIST_OFF_LSB +: RBK_OFFSET_WID];
   endfunction

   function automatic lp_t hist_target(hist_t e, int nb_lpid);
      return lp_t'(e >> HIST_TGT_LSB) & lp_mask(nb_lpid);
   endfunction

   function automatic hist_t make_hist(logic [TIME_WID-1:0] tm, logic typ,
                                       logic [RBK_OFFSET_WID-1:0] off, lp_t tgt, int nb_lpid);
      hist_t e;
      e = HIST_WID'(tgt & lp_mask(nb_lpid)) << HIST_TGT_LSB;
      e[HIST_OFF_LSB +: RBK_OFFSET_WID] = off;
      e[HIST_TYPE_BIT] = typ;
      e[TIME_WID-1:0] = tm;
      return e;
   endfunction

   // cancellation of the event an entry once generated
   function automatic logic [MSG_WID-1:0] make_cancel(hist_t e, int nb_lpid);
      logic [TIME_WID-1:0] t;
      t = hist_time(e) + {{(TIME_WID-RBK_OFFSET_WID){1'b0}}, hist_offset(e)};
      return make_msg(EVT_CANCEL, hist_target(e, nb_lpid), t, nb_lpid);
   endfunction

endpackage

/* verilog/fwft_fifo.sv */
module fwft_fifo #(
   parameter int DEPTH = 16
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       clear,
   input  logic                       wr_en,
   input  phold_pkg::hist_t           din,
   input  logic                       rd_en,
   output phold_pkg::hist_t           dout,
   output logic                       empty,
   output logic [$clog2(DEPTH+1)-1:0] count
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   phold_pkg::hist_t mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic do_wr;
   logic do_rd;

   assign empty = (count == '0);
   assign do_wr = wr_en && (count != CNT_W'(DEPTH));
   assign do_rd = rd_en && !empty;
   // head entry shows without a read
   assign dout = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (!rst_n || clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         if (do_wr && !do_rd) begin
            count <= count + 1'b1;
         end else if (do_rd && !do_wr) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
   end

endmodule

/* verilog/hist_port.sv */
module hist_port #(
   parameter int NB_LPID = 3,
   parameter int NB_HIST_DEPTH = 4
) (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            start,
   input  logic                            write_mode,
   input  logic [NB_LPID-1:0]              lp,
   input  logic [NB_HIST_DEPTH:0]          size,
   output logic                            hist_rq,
   output logic                            hist_wr_en,
   output logic [NB_LPID+NB_HIST_DEPTH-1:0] hist_addr,
   input  logic                            hist_access_grant,
   output logic                            hist_done,
   output logic                            hist_entry_vld
);

   phold_pkg::hist_state_t state;
   logic [NB_HIST_DEPTH:0] idx;
   logic [NB_HIST_DEPTH:0] size_q;
   logic mode_q;
   logic last;

   // each LP owns 2**NB_HIST_DEPTH slots
   assign hist_addr = {lp, idx[NB_HIST_DEPTH-1:0]};
   assign last = (idx == size_q - 1'b1);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= phold_pkg::HIST_IDLE;
         hist_rq <= 1'b0;
         hist_wr_en <= 1'b0;
         hist_done <= 1'b0;
         hist_entry_vld <= 1'b0;
         idx <= '0;
         mode_q <= 1'b0;
      end else begin
         hist_done <= 1'b0;
         hist_entry_vld <= 1'b0;
         case (state)
            phold_pkg::HIST_IDLE: begin
               if (start) begin
                  idx <= '0;
                  mode_q <= write_mode;
                  if (size == '0) begin
                     hist_done <= 1'b1;
                  end else begin
                     hist_rq <= 1'b1;
                     hist_wr_en <= write_mode;
                     state <= phold_pkg::HIST_WAIT;
                  end
               end
            end
            // one idle cycle between grants
            phold_pkg::HIST_REQ: begin
               hist_rq <= 1'b1;
               hist_wr_en <= mode_q;
               state <= phold_pkg::HIST_WAIT;
            end
            phold_pkg::HIST_WAIT: begin
               if (hist_access_grant) begin
                  hist_rq <= 1'b0;
                  hist_wr_en <= 1'b0;
                  idx <= idx + 1'b1;
                  hist_entry_vld <= !mode_q;
                  if (last) begin
                     hist_done <= 1'b1;
                     state <= phold_pkg::HIST_IDLE;
                  end else begin
                     state <= phold_pkg::HIST_REQ;
                  end
               end
            end
            default: state <= phold_pkg::HIST_IDLE;
         endcase
      end
   end

   // write count shrinks as entries drain, so hold it
   always_ff @(posedge clk) begin
      if (start) begin
         size_q <= size;
      end
   end

endmodule

/* verilog/hist_filter.sv */
module hist_filter #(
   parameter int NB_LPID = 3
) (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              clear,
   input  logic                              hist_entry_vld,
   input  phold_pkg::hist_t                  entry,
   input  logic [phold_pkg::TIME_WID-1:0]    cur_time,
   input  logic                              cur_type,
   input  logic [phold_pkg::TIME_WID-1:0]    gvt,
   output logic                              keep_entry,
   output logic                              rollback_entry,
   output logic                              discard_cur,
   output logic                              gen_cancel,
   output logic [phold_pkg::MSG_WID-1:0]     cancel_msg
);

   logic [phold_pkg::TIME_WID-1:0] ent_time;
   logic ent_type;
   logic expired;
   logic is_match;
   logic is_later;

   assign ent_time = phold_pkg::hist_time(entry);
   assign ent_type = phold_pkg::hist_type(entry);

   // older than gvt, can never be rolled back
   assign expired = (ent_time < gvt);
   // cancel/regular pair annihilates, once per event
   assign is_match = !expired && (ent_type != cur_type) && (ent_time == cur_time) &&
                     !discard_cur;
   assign is_later = !expired && !is_match && (cur_type == phold_pkg::EVT_REGULAR) &&
                     (ent_type == phold_pkg::EVT_REGULAR) && (ent_time > cur_time);

   assign rollback_entry = hist_entry_vld && is_later;
   assign keep_entry = hist_entry_vld && !expired && !is_match && !is_later;

   always_ff @(posedge clk) begin
      if (!rst_n || clear) begin
         discard_cur <= 1'b0;
         gen_cancel <= 1'b0;
      end else if (hist_entry_vld && is_match) begin
         discard_cur <= 1'b1;
         // matched regular entry was already processed
         if (cur_type == phold_pkg::EVT_CANCEL) begin
            gen_cancel <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (hist_entry_vld && is_match && cur_type == phold_pkg::EVT_CANCEL) begin
         cancel_msg <= phold_pkg::make_cancel(entry, NB_LPID);
      end
   end

endmodule

/* verilog/event_sequencer.sv */
module event_sequencer #(
   parameter int NB_LPID = 3
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           event_start,
   input  logic [NB_LPID-1:0]             cur_lp,
   input  logic [phold_pkg::TIME_WID-1:0] cur_time,
   input  logic                           cur_type,
   input  logic [phold_pkg::NB_RND-1:0]   rnd,
   input  logic                           hist_done,
   input  logic                           discard_cur,
   input  logic                           gen_cancel,
   input  logic [phold_pkg::MSG_WID-1:0]  cancel_msg,
   input  phold_pkg::hist_t               rbk_entry,
   input  logic                           rbk_empty,
   input  logic                           ack,
   output logic                           hist_start,
   output logic                           hist_write,
   output logic                           gen_entry_wr,
   output phold_pkg::hist_t               gen_entry,
   output logic                           rbk_rd_en,
   output logic                           new_event_ready,
   output logic [phold_pkg::MSG_WID-1:0]  out_event_msg,
   output logic                           ready,
   output logic                           fifo_clear
);

   localparam int TW = phold_pkg::TIME_WID;
   localparam int OW = phold_pkg::RBK_OFFSET_WID;
   localparam int RW = phold_pkg::TIME_RND_WID;
   // target comes from the middle third of the random word
   localparam int TGT_LSB = phold_pkg::NB_RND / 3;

   phold_pkg::core_state_t state;
   logic rbk_phase;
   logic [OW-1:0] evt_gap;
   logic [TW-1:0] new_time;
   logic [NB_LPID-1:0] new_target;
   logic [phold_pkg::MSG_WID-1:0] new_msg;
   logic [phold_pkg::MSG_WID-1:0] null_msg;
   logic [phold_pkg::MSG_WID-1:0] rbk_msg;
   logic [phold_pkg::MSG_WID-1:0] first_msg;

   assign evt_gap = phold_pkg::MIN_EVT_GAP + {{(OW-RW){1'b0}}, rnd[RW-1:0]};
   assign new_time = cur_time + {{(TW-OW){1'b0}}, evt_gap};
   assign new_target = rnd[TGT_LSB +: NB_LPID];

   assign new_msg = phold_pkg::make_msg(phold_pkg::EVT_REGULAR, phold_pkg::lp_t'(new_target),
                                        new_time, NB_LPID);
   assign null_msg = phold_pkg::make_msg(phold_pkg::EVT_CANCEL, '0, '0, NB_LPID);
   // cancel first, then the re-issued event back to this LP
   assign rbk_msg = rbk_phase ?
                    phold_pkg::make_msg(phold_pkg::EVT_REGULAR, phold_pkg::lp_t'(cur_lp),
                                        phold_pkg::hist_time(rbk_entry), NB_LPID) :
                    phold_pkg::make_cancel(rbk_entry, NB_LPID);

   // record keeps the gap so the new event can be cancelled later
   assign gen_entry = phold_pkg::make_hist(cur_time, cur_type, evt_gap,
                                           phold_pkg::lp_t'(new_target), NB_LPID);

   always_comb begin
      if (discard_cur && gen_cancel) begin
         first_msg = cancel_msg;
      end else if (discard_cur || cur_type == phold_pkg::EVT_CANCEL) begin
         first_msg = null_msg;
      end else begin
         first_msg = new_msg;
      end
   end

   assign ready = (state == phold_pkg::IDLE);
   assign fifo_clear = (state == phold_pkg::IDLE);
   assign new_event_ready = (state == phold_pkg::WAIT);
   assign hist_write = (state == phold_pkg::WRITE_HIST);
   assign gen_entry_wr = (state == phold_pkg::GEN_EVT) && !discard_cur;
   assign rbk_rd_en = new_event_ready && ack && rbk_phase;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= phold_pkg::IDLE;
         hist_start <= 1'b0;
         rbk_phase <= 1'b0;
      end else begin
         hist_start <= 1'b0;
         case (state)
            phold_pkg::IDLE: begin
               if (event_start) begin
                  state <= phold_pkg::READ_HIST;
                  hist_start <= 1'b1;
                  rbk_phase <= 1'b0;
               end
            end
            phold_pkg::READ_HIST: begin
               if (hist_done) begin
                  state <= phold_pkg::GEN_EVT;
               end
            end
            phold_pkg::GEN_EVT: begin
               state <= phold_pkg::WRITE_HIST;
               hist_start <= 1'b1;
            end
            phold_pkg::WRITE_HIST: begin
               if (hist_done) begin
                  state <= phold_pkg::SEND_EVT;
               end
            end
            phold_pkg::SEND_EVT: state <= phold_pkg::WAIT;
            phold_pkg::WAIT: begin
               if (ack) begin
                  if (rbk_phase) begin
                     rbk_phase <= 1'b0;
                  end else if (rbk_empty) begin
                     state <= phold_pkg::IDLE;
                  end else begin
                     rbk_phase <= 1'b1;
                  end
               end
            end
            default: state <= phold_pkg::IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == phold_pkg::SEND_EVT) begin
         out_event_msg <= first_msg;
      end else if (new_event_ready && ack && (rbk_phase || !rbk_empty)) begin
         out_event_msg <= rbk_msg;
      end
   end

endmodule

/* verilog/phold_core.sv */
module phold_core #(
   parameter int NB_LPID = 3,
   parameter int NB_HIST_DEPTH = 4
) (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              event_valid,
   input  logic [phold_pkg::MSG_WID-1:0]     event_msg,
   input  logic [phold_pkg::TIME_WID-1:0]    global_time,
   input  logic [phold_pkg::NB_RND-1:0]      random_in,
   input  logic [NB_HIST_DEPTH-1:0]          hist_size,
   output logic                              ready,
   output logic                              new_event_ready,
   output logic [phold_pkg::MSG_WID-1:0]     out_event_msg,
   input  logic                              ack,
   output logic                              hist_rq,
   output logic                              hist_wr_en,
   output logic [NB_LPID+NB_HIST_DEPTH-1:0]  hist_addr,
   output phold_pkg::hist_t                  hist_data_wr,
   input  phold_pkg::hist_t                  hist_data_rd,
   input  logic                              hist_access_grant
);

   localparam int BUF_DEPTH = 2 ** NB_HIST_DEPTH;

   logic [NB_LPID-1:0] cur_lp;
   logic [phold_pkg::TIME_WID-1:0] cur_time;
   logic cur_type;
   logic [phold_pkg::TIME_WID-1:0] gvt;
   logic [phold_pkg::NB_RND-1:0] rnd;
   logic [NB_HIST_DEPTH-1:0] size_q;
   phold_pkg::hist_t hist_q;

   logic hist_start;
   logic hist_write;
   logic hist_done;
   logic hist_entry_vld;
   logic [NB_HIST_DEPTH:0] port_size;
   logic keep_entry;
   logic rollback_entry;
   logic discard_cur;
   logic gen_cancel;
   logic [phold_pkg::MSG_WID-1:0] cancel_msg;
   logic gen_entry_wr;
   phold_pkg::hist_t gen_entry;
   logic fifo_clear;
   logic hbuf_wr;
   logic hbuf_rd;
   phold_pkg::hist_t hbuf_din;
   logic [NB_HIST_DEPTH:0] hbuf_cnt;
   logic rbk_rd_en;
   logic rbk_empty;
   phold_pkg::hist_t rbk_entry;

   always_ff @(posedge clk) begin
      if (event_valid) begin
         cur_lp <= NB_LPID'(phold_pkg::msg_lp(event_msg, NB_LPID));
         cur_time <= phold_pkg::msg_time(event_msg);
         cur_type <= phold_pkg::msg_type(event_msg, NB_LPID);
         gvt <= global_time;
         rnd <= random_in;
         size_q <= hist_size;
      end
      if (hist_access_grant && !hist_wr_en) begin
         hist_q <= hist_data_rd;
      end
   end

   // read the stored size, write back what the buffer holds
   assign port_size = hist_write ? hbuf_cnt : {1'b0, size_q};

   assign hbuf_wr = keep_entry || gen_entry_wr;
   assign hbuf_din = gen_entry_wr ? gen_entry : hist_q;
   assign hbuf_rd = hist_wr_en && hist_access_grant;

   event_sequencer #(
      .NB_LPID(NB_LPID)
   ) u_seq (
      .clk(clk),
      .rst_n(rst_n),
      .event_start(event_valid),
      .cur_lp(cur_lp),
      .cur_time(cur_time),
      .cur_type(cur_type),
      .rnd(rnd),
      .hist_done(hist_done),
      .discard_cur(discard_cur),
      .gen_cancel(gen_cancel),
      .cancel_msg(cancel_msg),
      .rbk_entry(rbk_entry),
      .rbk_empty(rbk_empty),
      .ack(ack),
      .hist_start(hist_start),
      .hist_write(hist_write),
      .gen_entry_wr(gen_entry_wr),
      .gen_entry(gen_entry),
      .rbk_rd_en(rbk_rd_en),
      .new_event_ready(new_event_ready),
      .out_event_msg(out_event_msg),
      .ready(ready),
      .fifo_clear(fifo_clear)
   );

   hist_port #(
      .NB_LPID(NB_LPID),
      .NB_HIST_DEPTH(NB_HIST_DEPTH)
   ) u_port (
      .clk(clk),
      .rst_n(rst_n),
      .start(hist_start),
      .write_mode(hist_write),
      .lp(cur_lp),
      .size(port_size),
      .hist_rq(hist_rq),
      .hist_wr_en(hist_wr_en),
      .hist_addr(hist_addr),
      .hist_access_grant(hist_access_grant),
      .hist_done(hist_done),
      .hist_entry_vld(hist_entry_vld)
   );

   hist_filter #(
      .NB_LPID(NB_LPID)
   ) u_filter (
      .clk(clk),
      .rst_n(rst_n),
      .clear(fifo_clear),
      .hist_entry_vld(hist_entry_vld),
      .entry(hist_q),
      .cur_time(cur_time),
      .cur_type(cur_type),
      .gvt(gvt),
      .keep_entry(keep_entry),
      .rollback_entry(rollback_entry),
      .discard_cur(discard_cur),
      .gen_cancel(gen_cancel),
      .cancel_msg(cancel_msg)
   );

   fwft_fifo #(
      .DEPTH(BUF_DEPTH)
   ) hist_buffer (
      .clk(clk),
      .rst_n(rst_n),
      .clear(fifo_clear),
      .wr_en(hbuf_wr),
      .din(hbuf_din),
      .rd_en(hbuf_rd),
      .dout(hist_data_wr),
      .empty(),
      .count(hbuf_cnt)
   );

   fwft_fifo #(
      .DEPTH(BUF_DEPTH)
   ) rbk_buffer (
      .clk(clk),
      .rst_n(rst_n),
      .clear(fifo_clear),
      .wr_en(rollback_entry),
      .din(hist_q),
      .rd_en(rbk_rd_en),
      .dout(rbk_entry),
      .empty(rbk_empty),
      .count()
   );

endmodule

/* verif/phold_core_chk.sv */
module phold_core_chk (
   input logic                          clk,
   input logic                          rst_n,
   input logic                          hist_rq,
   input logic                          hist_wr_en,
   input logic                          hist_access_grant,
   input logic                          ready,
   input logic                          new_event_ready,
   input logic                          ack,
   input logic [phold_pkg::MSG_WID-1:0] out_event_msg
);

   // failed properties so far
   int fail_cnt = 0;

   // write enable only rides on a request
   a_wr_in_rq: assert property (@(posedge clk) disable iff (!rst_n)
      hist_wr_en |-> hist_rq)
      else begin
         fail_cnt++;
         $error("hist_wr_en high without hist_rq");
      end

   a_rq_held: assert property (@(posedge clk) disable iff (!rst_n)
      hist_rq && !hist_access_grant |=> hist_rq)
      else begin
         fail_cnt++;
         $error("hist_rq dropped before grant");
      end

   a_ready_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(ready && new_event_ready))
      else begin
         fail_cnt++;
         $error("ready and new_event_ready high together");
      end

   // message held until the consumer takes it
   a_msg_stable: assert property (@(posedge clk) disable iff (!rst_n)
      new_event_ready && !ack |=> new_event_ready && $stable(out_event_msg))
      else begin
         fail_cnt++;
         $error("out_event_msg changed without ack");
      end

endmodule

/* verif/phold_core_tb.sv */
module phold_core_tb;

   localparam int NB_LPID = 3;
   localparam int NB_HIST_DEPTH = 4;
   localparam int CLK_PERIOD = 100;
   localparam int N_LP = 8;
   localparam int N_EVENTS = 48;
   localparam int SLOTS = 16;
   localparam int WATCHDOG_CYCLES = N_EVENTS * 400;

   logic clk = 1'b0;
   logic rst_n;
   logic event_valid;
   logic [31:0] event_msg;
   logic [15:0] global_time;
   logic [23:0] random_in;
   logic [3:0] hist_size;
   logic ready;
   logic new_event_ready;
   logic [31:0] out_event_msg;
   logic ack;
   logic hist_rq;
   logic hist_wr_en;
   logic [6:0] hist_addr;
   logic [31:0] hist_data_wr;
   logic [31:0] hist_data_rd;
   logic hist_access_grant;

   integer seed = 94860;
   int msg_err = 0;
   int wr_err = 0;
   int proto_err = 0;
   int ev_done = 0;

   // memory seen by the DUT, and the reference copy
   logic [31:0] mem [N_LP * SLOTS];
   logic [31:0] ref_mem [N_LP * SLOTS];
   int hist_cnt [N_LP];

   logic [31:0] exp_msg_q [$];
   logic [31:0] exp_wr_data_q [$];
   logic [6:0] exp_wr_addr_q [$];

   always #(CLK_PERIOD / 2) clk = ~clk;

   phold_core #(
      .NB_LPID(NB_LPID),
      .NB_HIST_DEPTH(NB_HIST_DEPTH)
   ) UUT (
      .clk(clk),
      .rst_n(rst_n),
      .event_valid(event_valid),
      .event_msg(event_msg),
      .global_time(global_time),
      .random_in(random_in),
      .hist_size(hist_size),
      .ready(ready),
      .new_event_ready(new_event_ready),
      .out_event_msg(out_event_msg),
      .ack(ack),
      .hist_rq(hist_rq),
      .hist_wr_en(hist_wr_en),
      .hist_addr(hist_addr),
      .hist_data_wr(hist_data_wr),
      .hist_data_rd(hist_data_rd),
      .hist_access_grant(hist_access_grant)
   );

   bind phold_core phold_core_chk u_chk (
      .clk(clk),
      .rst_n(rst_n),
      .hist_rq(hist_rq),
      .hist_wr_en(hist_wr_en),
      .hist_access_grant(hist_access_grant),
      .ready(ready),
      .new_event_ready(new_event_ready),
      .ack(ack),
      .out_event_msg(out_event_msg)
   );

   function automatic int rand_below(int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   // message: time in 15:0, lp in 18:16, type in 19
   function automatic logic [31:0] msg_word(logic typ, logic [2:0] lp, logic [15:0] tm);
      return {12'd0, typ, lp, tm};
   endfunction

   // undo the event an entry sent: its target at time plus offset
   function automatic logic [31:0] cancel_of(logic [31:0] ent);
      return msg_word(1'b1, ent[27:25], ent[15:0] + {8'd0, ent[24:17]});
   endfunction

   // expected messages and write-backs of one event, returns new history count
   function automatic int predict_event(int lp, logic typ, logic [15:0] tm,
                                        logic [15:0] gvt_v, logic [23:0] rnd_v);
      logic [31:0] ent;
      logic [31:0] cancel_m;
      logic [31:0] kept [$];
      logic [31:0] rbk [$];
      logic [7:0] gap;
      logic [2:0] tgt;
      logic matched;
      matched = 1'b0;
      cancel_m = '0;
      for (int i = 0; i < hist_cnt[lp]; i++) begin
         ent = ref_mem[lp * SLOTS + i];
         // below gvt the entry is simply gone
         if (ent[15:0] >= gvt_v) begin
            if (ent[16] != typ && ent[15:0] == tm && !matched) begin
               matched = 1'b1;
               if (typ) begin
                  cancel_m = cancel_of(ent);
               end
            end else if (!typ && !ent[16] && ent[15:0] > tm) begin
               rbk.push_back(ent);
            end else begin
               kept.push_back(ent);
            end
         end
      end
      gap = 8'd10 + {2'b00, rnd_v[5:0]};
      tgt = rnd_v[10:8];
      if (!matched) begin
         kept.push_back({4'd0, tgt, gap, typ, tm});
      end
      if (matched && typ) begin
         exp_msg_q.push_back(cancel_m);
      end else if (matched || typ) begin
         exp_msg_q.push_back(msg_word(1'b1, 3'd0, 16'd0));
      end else begin
         exp_msg_q.push_back(msg_word(1'b0, tgt, tm + {8'd0, gap}));
      end
      foreach (rbk[j]) begin
         exp_msg_q.push_back(cancel_of(rbk[j]));
         exp_msg_q.push_back(msg_word(1'b0, 3'(lp), rbk[j][15:0]));
      end
      foreach (kept[j]) begin
         ref_mem[lp * SLOTS + j] = kept[j];
         exp_wr_addr_q.push_back(7'(lp * SLOTS + j));
         exp_wr_data_q.push_back(kept[j]);
      end
      return kept.size();
   endfunction

   // grants after 1 to 3 cycles, one request at a time
   initial begin : history_responder
      int wait_cyc;
      hist_access_grant = 1'b0;
      hist_data_rd = '0;
      wait (rst_n === 1'b1);
      mem = ref_mem;
      forever begin
         @(negedge clk);
         if (rst_n && hist_rq) begin
            wait_cyc = 1 + rand_below(3);
            repeat (wait_cyc - 1) @(negedge clk);
            hist_access_grant = 1'b1;
            if (hist_wr_en) begin
               mem[hist_addr] = hist_data_wr;
            end else begin
               hist_data_rd = mem[hist_addr];
            end
            @(negedge clk);
            hist_access_grant = 1'b0;
         end
      end
   end

   always @(posedge clk) begin : compare_outputs
      logic [31:0] exp_v;
      logic [6:0] exp_a;
      if (rst_n && hist_rq && hist_wr_en && hist_access_grant) begin
         assert (exp_wr_data_q.size() > 0) else begin
            wr_err++;
            $display("ERROR: unexpected history write to %h at %0t", hist_addr, $time);
         end
         if (exp_wr_data_q.size() > 0) begin
            exp_a = exp_wr_addr_q.pop_front();
            exp_v = exp_wr_data_q.pop_front();
            assert (hist_addr == exp_a) else begin
               wr_err++;
               $display("FAILED %0t hist_addr got %h expected %h", $time, hist_addr, exp_a);
            end
            assert (hist_data_wr == exp_v) else begin
               wr_err++;
               $display("FAILED %0t hist_data_wr got %h expected %h",
                        $time, hist_data_wr, exp_v);
            end
         end
      end
      if (rst_n && new_event_ready && ack) begin
         assert (exp_msg_q.size() > 0) else begin
            msg_err++;
            $display("ERROR: extra message %h acked at %0t", out_event_msg, $time);
         end
         if (exp_msg_q.size() > 0) begin
            exp_v = exp_msg_q.pop_front();
            assert (out_event_msg == exp_v) else begin
               msg_err++;
               $display("FAILED %0t out_event_msg got %h expected %h",
                        $time, out_event_msg, exp_v);
            end
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("ERROR: run timed out after %0d of %0d events", ev_done, N_EVENTS);
      $display("Verification failed");
      $finish;
   end

   initial begin : stimulus
      int lp;
      int cnt;
      int pick;
      int new_cnt;
      logic typ;
      logic [15:0] tm;
      logic [15:0] gvt_v;
      logic [23:0] rnd_v;
      logic [31:0] ent;
      rst_n = 1'b0;
      event_valid = 1'b0;
      event_msg = '0;
      global_time = '0;
      random_in = '0;
      hist_size = '0;
      ack = 1'b0;
      // unused slots carry their own address
      for (int a = 0; a < N_LP * SLOTS; a++) begin
         ref_mem[a] = 32'(a) * 32'h0001_0001;
      end
      for (int l = 0; l < N_LP; l++) begin
         hist_cnt[l] = rand_below(5);
         for (int i = 0; i < hist_cnt[l]; i++) begin
            ref_mem[l * SLOTS + i] = {4'd0, 3'(rand_below(8)), 8'(10 + rand_below(64)),
                                      rand_below(4) == 0, 16'(8 * i + rand_below(8))};
         end
      end
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      assert (ready && !new_event_ready && !hist_rq && !hist_wr_en) else begin
         proto_err++;
         $display("ERROR: outputs not idle after reset");
      end
      for (int k = 0; k < N_EVENTS; k++) begin
         lp = k % N_LP;
         cnt = hist_cnt[lp];
         gvt_v = 16'((k / N_LP) * 12);
         pick = rand_below(4);
         typ = 1'b0;
         tm = gvt_v + 16'(20 + rand_below(40));
         // aim at a stored entry so the pair annihilates
         if (pick == 0 && cnt > 0) begin
            ent = ref_mem[lp * SLOTS + rand_below(cnt)];
            tm = ent[15:0];
            typ = ~ent[16];
         end else if (pick == 1) begin
            typ = 1'b1;
         end
         rnd_v = 24'($random(seed));
         new_cnt = predict_event(lp, typ, tm, gvt_v, rnd_v);
         event_valid = 1'b1;
         event_msg = msg_word(typ, 3'(lp), tm);
         global_time = gvt_v;
         random_in = rnd_v;
         hist_size = 4'(cnt);
         @(negedge clk);
         event_valid = 1'b0;
         // ack as a single-cycle pulse at random
         while (!ready) begin
            @(negedge clk);
            if (ack) begin
               ack = 1'b0;
            end else if (new_event_ready && rand_below(2) == 0) begin
               ack = 1'b1;
            end
         end
         assert (exp_msg_q.size() == 0) else begin
            proto_err++;
            $display("ERROR: event %0d ended with %0d messages missing", k, exp_msg_q.size());
         end
         assert (exp_wr_data_q.size() == 0) else begin
            proto_err++;
            $display("ERROR: event %0d ended with %0d writes missing", k, exp_wr_data_q.size());
         end
         exp_msg_q.delete();
         exp_wr_addr_q.delete();
         exp_wr_data_q.delete();
         hist_cnt[lp] = new_cnt;
         ev_done++;
      end
      repeat (2) @(negedge clk);
      $display("errors: message %0d, history write %0d, protocol %0d, assertion %0d",
               msg_err, wr_err, proto_err, UUT.u_chk.fail_cnt);
      if (msg_err + wr_err + proto_err + UUT.u_chk.fail_cnt == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

/* tb.f */
verilog/phold_pkg.sv
verilog/fwft_fifo.sv
verilog/hist_port.sv
verilog/hist_filter.sv
verilog/event_sequencer.sv
verilog/phold_core.sv
verif/phold_core_chk.sv
verif/phold_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= phold_core_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := Verification passed

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
